//--- verilog/mdom_pkg.sv
//**********************************************************
// mdom slow-control package
// register map, field widths, spi timing and fsm encodings
//**********************************************************
`default_nettype none

package mdom_pkg;

  // firmware version
  localparam logic [15:0] FW_VNUM = 16'h2;

  // axi4-lite geometry, byte address is index * 4
  localparam int REG_ADDR_W = 12;
  localparam int AXI_ADDR_W = REG_ADDR_W + 2;
  localparam int AXI_DATA_W = 32;

  // register indices
  localparam logic [REG_ADDR_W-1:0] REG_VNUM         = 12'hfff;
  localparam logic [REG_ADDR_W-1:0] REG_ADC_RESET    = 12'hee5;
  localparam logic [REG_ADDR_W-1:0] REG_ADC_SPI_SEL  = 12'hee4;
  localparam logic [REG_ADDR_W-1:0] REG_ADC_SPI_TASK = 12'hee3;
  localparam logic [REG_ADDR_W-1:0] REG_ADC_WR_HI    = 12'hee2;
  localparam logic [REG_ADDR_W-1:0] REG_ADC_WR_LO    = 12'hee1;
  localparam logic [REG_ADDR_W-1:0] REG_ADC_RD       = 12'hee0;
  localparam logic [REG_ADDR_W-1:0] REG_DAC_SPI_SEL  = 12'hedf;
  localparam logic [REG_ADDR_W-1:0] REG_DAC_CHIP_SEL = 12'hede;
  localparam logic [REG_ADDR_W-1:0] REG_DAC_SPI_TASK = 12'hedd;
  localparam logic [REG_ADDR_W-1:0] REG_DAC_WR_HI    = 12'hedc;
  localparam logic [REG_ADDR_W-1:0] REG_DAC_WR_LO    = 12'hedb;

  // board population
  localparam int N_ADCS      = 6;
  localparam int N_DACS      = 3;
  localparam int N_DAC_CHIPS = 3;
  localparam int N_LEDS      = 3;

  // spi frames
  localparam int ADC_FRAME_W = 24;
  localparam int ADC_RD_W    = 8;
  localparam int DAC_FRAME_W = 32;

  // lclk cycles per half bit, shortened for simulation
  localparam int SPI_HALF_PERIOD = 4;
  localparam int SPI_HALF_W      = $clog2(SPI_HALF_PERIOD);

  // led pattern step
  localparam int LED_STEP  = 16;
  localparam int LED_CNT_W = $clog2(LED_STEP);

  typedef enum logic {AXW_IDLE, AXW_RESP} axil_state_t;

  typedef enum logic [1:0] {SPI_IDLE, SPI_LEAD, SPI_TRAIL, SPI_DONE} spi_state_t;

endpackage

`default_nettype wire

//--- verilog/mdom_axil_regs.sv
//**********************************************************
// mdom axi4-lite register block
// slow-control register map and spi task request/ack logic
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module mdom_axil_regs import mdom_pkg::*; (
  input  wire                   i_lclk,
  input  wire                   i_lclk_rst,
  input  wire                   i_awvalid,
  input  wire  [AXI_ADDR_W-1:0] i_awaddr,
  output logic                  o_awready,
  input  wire                   i_wvalid,
  input  wire  [AXI_DATA_W-1:0] i_wdata,
  output logic                  o_wready,
  output logic                  o_bvalid,
  output logic [1:0]            o_bresp,
  input  wire                   i_bready,
  input  wire                   i_arvalid,
  input  wire  [AXI_ADDR_W-1:0] i_araddr,
  output logic                  o_arready,
  output logic                  o_rvalid,
  output logic [AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]            o_rresp,
  input  wire                   i_rready,
  output logic                  o_adc_reset,
  output logic [N_ADCS-1:0]     o_adc_sel,
  output logic                  o_adc_req,
  output logic [ADC_FRAME_W-1:0] o_adc_wr_data,
  input  wire                   i_adc_ack,
  input  wire  [ADC_RD_W-1:0]   i_adc_rd_data,
  output logic [N_DACS-1:0]     o_dac_sel,
  output logic [N_DAC_CHIPS-1:0] o_dac_chip_sel,
  output logic                  o_dac_req,
  output logic [DAC_FRAME_W-1:0] o_dac_wr_data,
  input  wire                   i_dac_ack
);

  axil_state_t           wr_state;
  logic                  aw_rdy_q;
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_idx;
  logic [REG_ADDR_W-1:0] rd_idx;
  logic [AXI_DATA_W-1:0] rd_val;
  logic [7:0]            adc_wr_hi_q;
  logic [15:0]           adc_wr_lo_q;
  logic [ADC_RD_W-1:0]   adc_rd_q;
  logic [15:0]           dac_wr_hi_q;
  logic [15:0]           dac_wr_lo_q;

  // word index from byte address
  assign wr_idx = i_awaddr[AXI_ADDR_W-1:2];
  assign rd_idx = i_araddr[AXI_ADDR_W-1:2];

  // aw and w share one ready
  assign o_awready = aw_rdy_q;
  assign o_wready  = aw_rdy_q;
  assign wr_en     = aw_rdy_q & i_awvalid & i_wvalid;
  assign o_bresp   = 2'b00;
  assign o_rresp   = 2'b00;

  assign o_adc_wr_data = {adc_wr_hi_q, adc_wr_lo_q};
  assign o_dac_wr_data = {dac_wr_hi_q, dac_wr_lo_q};

  // write channel fsm
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      wr_state <= AXW_IDLE;
      aw_rdy_q <= 1'b0;
      o_bvalid <= 1'b0;
    end else begin
      aw_rdy_q <= 1'b0;
      case (wr_state)
        AXW_IDLE: begin
          if (aw_rdy_q) begin
            o_bvalid <= 1'b1;
            wr_state <= AXW_RESP;
          end else if (i_awvalid && i_wvalid) begin
            aw_rdy_q <= 1'b1;
          end
        end
        AXW_RESP: begin
          // hold response until master takes it
          if (i_bready) begin
            o_bvalid <= 1'b0;
            wr_state <= AXW_IDLE;
          end
        end
        default: wr_state <= AXW_IDLE;
      endcase
    end
  end

  // control registers and task bits
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      o_adc_reset    <= 1'b0;
      o_adc_sel      <= '0;
      o_adc_req      <= 1'b0;
      o_dac_sel      <= '0;
      o_dac_chip_sel <= '0;
      o_dac_req      <= 1'b0;
    end else begin
      if (wr_en) begin
        case (wr_idx)
          REG_ADC_RESET:    o_adc_reset    <= i_wdata[0];
          REG_ADC_SPI_SEL:  o_adc_sel      <= i_wdata[N_ADCS-1:0];
          REG_DAC_SPI_SEL:  o_dac_sel      <= i_wdata[N_DACS-1:0];
          REG_DAC_CHIP_SEL: o_dac_chip_sel <= i_wdata[N_DAC_CHIPS-1:0];
          default: ;
        endcase
      end
      // ack wins, writes while busy change nothing
      if (i_adc_ack) begin
        o_adc_req <= 1'b0;
      end else if (wr_en && wr_idx == REG_ADC_SPI_TASK && i_wdata[0]) begin
        o_adc_req <= 1'b1;
      end
      if (i_dac_ack) begin
        o_dac_req <= 1'b0;
      end else if (wr_en && wr_idx == REG_DAC_SPI_TASK && i_wdata[0]) begin
        o_dac_req <= 1'b1;
      end
    end
  end

  // frame data and adc read-back
  always_ff @(posedge i_lclk) begin
    if (wr_en) begin
      case (wr_idx)
        REG_ADC_WR_HI: adc_wr_hi_q <= i_wdata[7:0];
        REG_ADC_WR_LO: adc_wr_lo_q <= i_wdata[15:0];
        REG_DAC_WR_HI: dac_wr_hi_q <= i_wdata[15:0];
        REG_DAC_WR_LO: dac_wr_lo_q <= i_wdata[15:0];
        default: ;
      endcase
    end
    if (i_adc_ack) begin
      adc_rd_q <= i_adc_rd_data;
    end
  end

  // read decode, unmapped reads zero
  always_comb begin
    rd_val = '0;
    case (rd_idx)
      REG_VNUM:         rd_val[15:0]            = FW_VNUM;
      REG_ADC_RESET:    rd_val[0]               = o_adc_reset;
      REG_ADC_SPI_SEL:  rd_val[N_ADCS-1:0]      = o_adc_sel;
      REG_ADC_SPI_TASK: rd_val[0]               = o_adc_req;
      REG_ADC_WR_HI:    rd_val[7:0]             = adc_wr_hi_q;
      REG_ADC_WR_LO:    rd_val[15:0]            = adc_wr_lo_q;
      REG_ADC_RD:       rd_val[ADC_RD_W-1:0]    = adc_rd_q;
      REG_DAC_SPI_SEL:  rd_val[N_DACS-1:0]      = o_dac_sel;
      REG_DAC_CHIP_SEL: rd_val[N_DAC_CHIPS-1:0] = o_dac_chip_sel;
      REG_DAC_SPI_TASK: rd_val[0]               = o_dac_req;
      REG_DAC_WR_HI:    rd_val[15:0]            = dac_wr_hi_q;
      REG_DAC_WR_LO:    rd_val[15:0]            = dac_wr_lo_q;
      default: ;
    endcase
  end

  // read channel, one outstanding read
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      o_arready <= i_arvalid & ~o_arready & ~o_rvalid;
      if (o_arready && i_arvalid) begin
        o_rvalid <= 1'b1;
      end else if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_lclk) begin
    if (o_arready && i_arvalid) begin
      o_rdata <= rd_val;
    end
  end

  a_bvalid_hold: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    o_bvalid && !i_bready |=> o_bvalid)
    else $error("write response dropped before bready");

  // an engine ack only ever answers a pending request
  a_adc_ack_req: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    i_adc_ack |-> o_adc_req)
    else $error("adc ack without a pending request");

  a_dac_ack_req: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    i_dac_ack |-> o_dac_req)
    else $error("dac ack without a pending request");

endmodule

`default_nettype wire

//--- verilog/mdom_spi_master.sv
//**********************************************************
// spi shift engine
// one msb-first frame out on mosi, miso shifted in
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module mdom_spi_master import mdom_pkg::*; #(
  parameter int P_FRAME_W   = 24,
  parameter bit P_SCLK_IDLE = 1'b0
) (
  input  wire                  i_lclk,
  input  wire                  i_lclk_rst,
  input  wire                  i_req,
  input  wire  [P_FRAME_W-1:0] i_wr_data,
  input  wire                  i_miso,
  output logic                 o_ack,
  output logic [P_FRAME_W-1:0] o_rd_data,
  output logic                 o_sclk,
  output logic                 o_mosi
);

  localparam int BIT_CNT_W = $clog2(P_FRAME_W);

  spi_state_t            state;
  logic [SPI_HALF_W-1:0] half_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [P_FRAME_W-1:0]  tx_q;
  logic                  half_end;

  assign half_end = (half_cnt == SPI_HALF_W'(SPI_HALF_PERIOD - 1));

  // clock leaves idle only in the trailing half
  assign o_sclk    = (state == SPI_TRAIL) ? ~P_SCLK_IDLE : P_SCLK_IDLE;
  assign o_mosi    = (state == SPI_LEAD || state == SPI_TRAIL) & tx_q[P_FRAME_W-1];
  assign o_ack     = (state == SPI_DONE);

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      state    <= SPI_IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        SPI_IDLE: begin
          half_cnt <= '0;
          bit_cnt  <= '0;
          if (i_req) state <= SPI_LEAD;
        end
        SPI_LEAD: begin
          half_cnt <= half_end ? '0 : half_cnt + 1'b1;
          if (half_end) state <= SPI_TRAIL;
        end
        SPI_TRAIL: begin
          half_cnt <= half_end ? '0 : half_cnt + 1'b1;
          if (half_end) begin
            if (bit_cnt == BIT_CNT_W'(P_FRAME_W - 1)) begin
              state <= SPI_DONE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              state   <= SPI_LEAD;
            end
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // shift registers, tx steps at each bit boundary
  always_ff @(posedge i_lclk) begin
    if (state == SPI_IDLE && i_req) begin
      tx_q <= i_wr_data;
    end else if (state == SPI_TRAIL && half_end) begin
      tx_q <= {tx_q[P_FRAME_W-2:0], 1'b0};
    end
    // miso taken on the edge away from idle
    if (state == SPI_LEAD && half_end) begin
      o_rd_data <= {o_rd_data[P_FRAME_W-2:0], i_miso};
    end
  end

  // request must still be held when the frame completes
  a_ack_req: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    o_ack |-> i_req)
    else $error("spi ack without a held request");

endmodule

`default_nettype wire

//--- verilog/mdom_serial_ctrl.sv
//**********************************************************
// adc3424 and ad5668 serial control
// two spi engines plus enable, sync and bus routing
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module mdom_serial_ctrl import mdom_pkg::*; (
  input  wire                       i_lclk,
  input  wire                       i_lclk_rst,
  input  wire                       i_adc_req,
  input  wire  [N_ADCS-1:0]         i_adc_sel,
  input  wire  [ADC_FRAME_W-1:0]    i_adc_wr_data,
  input  wire                       i_adc_sdout,
  output logic                      o_adc_ack,
  output logic [ADC_RD_W-1:0]       o_adc_rd_data,
  output logic                      o_adc_sclk,
  output logic                      o_adc_sdata,
  output logic [N_ADCS-1:0]         o_adc_sen_n,
  input  wire                       i_dac_req,
  input  wire  [N_DACS-1:0]         i_dac_sel,
  input  wire  [N_DAC_CHIPS-1:0]    i_dac_chip_sel,
  input  wire  [DAC_FRAME_W-1:0]    i_dac_wr_data,
  output logic                      o_dac_ack,
  output logic [N_DACS-1:0]         o_dac_sclk,
  output logic [N_DACS-1:0]         o_dac_din,
  output logic [N_DACS*N_DAC_CHIPS-1:0] o_dac_sync_n
);

  logic [ADC_FRAME_W-1:0] adc_rd_frame;
  logic                   dac_sclk;
  logic                   dac_mosi;

  // adc clock idles low
  mdom_spi_master #(.P_FRAME_W(ADC_FRAME_W), .P_SCLK_IDLE(1'b0)) adc_spi (
    .i_lclk    (i_lclk),
    .i_lclk_rst(i_lclk_rst),
    .i_req     (i_adc_req),
    .i_wr_data (i_adc_wr_data),
    .i_miso    (i_adc_sdout),
    .o_ack     (o_adc_ack),
    .o_rd_data (adc_rd_frame),
    .o_sclk    (o_adc_sclk),
    .o_mosi    (o_adc_sdata)
  );

  // only the low byte carries register data
  assign o_adc_rd_data = adc_rd_frame[ADC_RD_W-1:0];
  assign o_adc_sen_n   = ~({N_ADCS{i_adc_req}} & i_adc_sel);

  // dac is write only, no miso
  mdom_spi_master #(.P_FRAME_W(DAC_FRAME_W), .P_SCLK_IDLE(1'b1)) dac_spi (
    .i_lclk    (i_lclk),
    .i_lclk_rst(i_lclk_rst),
    .i_req     (i_dac_req),
    .i_wr_data (i_dac_wr_data),
    .i_miso    (1'b0),
    .o_ack     (o_dac_ack),
    .o_rd_data (),
    .o_sclk    (dac_sclk),
    .o_mosi    (dac_mosi)
  );

  // unselected buses park sclk high, din low
  for (genvar b = 0; b < N_DACS; b++) begin : g_dac_bus
    assign o_dac_sclk[b] = i_dac_sel[b] ? dac_sclk : 1'b1;
    assign o_dac_din[b]  = i_dac_sel[b] & dac_mosi;
    for (genvar c = 0; c < N_DAC_CHIPS; c++) begin : g_sync
      assign o_dac_sync_n[b*N_DAC_CHIPS+c] = ~(i_dac_req & i_dac_sel[b] & i_dac_chip_sel[c]);
    end
  end

endmodule

`default_nettype wire

//--- verilog/mdom_led_sweep.sv
//**********************************************************
// status led sweep
// one-hot value bouncing across the leds
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module mdom_led_sweep import mdom_pkg::*; (
  input  wire               i_lclk,
  input  wire               i_lclk_rst,
  output logic [N_LEDS-1:0] o_led
);

  logic [LED_CNT_W-1:0] step_cnt;
  // 0 moves up, 1 moves down
  logic                 dir_down;

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      step_cnt <= '0;
      dir_down <= 1'b0;
      o_led    <= N_LEDS'(1);
    end else begin
      step_cnt <= step_cnt + 1'b1;
      if (step_cnt == LED_CNT_W'(LED_STEP - 1)) begin
        if (!dir_down) begin
          o_led <= o_led << 1;
          // turn around once the top led is reached
          if (o_led[N_LEDS-2]) dir_down <= 1'b1;
        end else begin
          o_led <= o_led >> 1;
          if (o_led[1]) dir_down <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/mdom_top.sv
//**********************************************************
// mdom mainboard slow-control top level
// axi4-lite registers, adc/dac serial ports and led sweep
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module mdom_top import mdom_pkg::*; (
  input  wire                       i_lclk,
  input  wire                       i_lclk_rst,
  // axi4-lite slave
  input  wire                       i_awvalid,
  input  wire  [AXI_ADDR_W-1:0]     i_awaddr,
  output logic                      o_awready,
  input  wire                       i_wvalid,
  input  wire  [AXI_DATA_W-1:0]     i_wdata,
  output logic                      o_wready,
  output logic                      o_bvalid,
  output logic [1:0]                o_bresp,
  input  wire                       i_bready,
  input  wire                       i_arvalid,
  input  wire  [AXI_ADDR_W-1:0]     i_araddr,
  output logic                      o_arready,
  output logic                      o_rvalid,
  output logic [AXI_DATA_W-1:0]     o_rdata,
  output logic [1:0]                o_rresp,
  input  wire                       i_rready,
  // adc3424 pins
  output logic                      o_adc_reset,
  output logic [N_ADCS-1:0]         o_adc_sen_n,
  output logic                      o_adc_sclk,
  output logic                      o_adc_sdata,
  input  wire                       i_adc_sdout,
  // ad5668 pins
  output logic [N_DACS-1:0]         o_dac_sclk,
  output logic [N_DACS-1:0]         o_dac_din,
  output logic [N_DACS*N_DAC_CHIPS-1:0] o_dac_sync_n,
  output logic [N_LEDS-1:0]         o_led
);

  logic                   adc_req;
  logic                   adc_ack;
  logic [N_ADCS-1:0]      adc_sel;
  logic [ADC_FRAME_W-1:0] adc_wr_data;
  logic [ADC_RD_W-1:0]    adc_rd_data;
  logic                   dac_req;
  logic                   dac_ack;
  logic [N_DACS-1:0]      dac_sel;
  logic [N_DAC_CHIPS-1:0] dac_chip_sel;
  logic [DAC_FRAME_W-1:0] dac_wr_data;

  mdom_axil_regs regs (
    .i_lclk        (i_lclk),
    .i_lclk_rst    (i_lclk_rst),
    .i_awvalid     (i_awvalid),
    .i_awaddr      (i_awaddr),
    .o_awready     (o_awready),
    .i_wvalid      (i_wvalid),
    .i_wdata       (i_wdata),
    .o_wready      (o_wready),
    .o_bvalid      (o_bvalid),
    .o_bresp       (o_bresp),
    .i_bready      (i_bready),
    .i_arvalid     (i_arvalid),
    .i_araddr      (i_araddr),
    .o_arready     (o_arready),
    .o_rvalid      (o_rvalid),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .i_rready      (i_rready),
    .o_adc_reset   (o_adc_reset),
    .o_adc_sel     (adc_sel),
    .o_adc_req     (adc_req),
    .o_adc_wr_data (adc_wr_data),
    .i_adc_ack     (adc_ack),
    .i_adc_rd_data (adc_rd_data),
    .o_dac_sel     (dac_sel),
    .o_dac_chip_sel(dac_chip_sel),
    .o_dac_req     (dac_req),
    .o_dac_wr_data (dac_wr_data),
    .i_dac_ack     (dac_ack)
  );

  mdom_serial_ctrl serial (
    .i_lclk        (i_lclk),
    .i_lclk_rst    (i_lclk_rst),
    .i_adc_req     (adc_req),
    .i_adc_sel     (adc_sel),
    .i_adc_wr_data (adc_wr_data),
    .i_adc_sdout   (i_adc_sdout),
    .o_adc_ack     (adc_ack),
    .o_adc_rd_data (adc_rd_data),
    .o_adc_sclk    (o_adc_sclk),
    .o_adc_sdata   (o_adc_sdata),
    .o_adc_sen_n   (o_adc_sen_n),
    .i_dac_req     (dac_req),
    .i_dac_sel     (dac_sel),
    .i_dac_chip_sel(dac_chip_sel),
    .i_dac_wr_data (dac_wr_data),
    .o_dac_ack     (dac_ack),
    .o_dac_sclk    (o_dac_sclk),
    .o_dac_din     (o_dac_din),
    .o_dac_sync_n  (o_dac_sync_n)
  );

  mdom_led_sweep leds (
    .i_lclk    (i_lclk),
    .i_lclk_rst(i_lclk_rst),
    .o_led     (o_led)
  );

endmodule

`default_nettype wire

//--- testbench/tb_mdom_checker.sv
//**********************************************************
// mdom slow-control checker
// captures spi frames and led moves, compares with expected
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mdom_checker import mdom_pkg::*; (
  input wire                          i_lclk,
  input wire                          i_lclk_rst,
  input wire                          i_adc_sclk,
  input wire                          i_adc_sdata,
  input wire [N_ADCS-1:0]             i_adc_sen_n,
  input wire [N_DACS-1:0]             i_dac_sclk,
  input wire [N_DACS-1:0]             i_dac_din,
  input wire [N_DACS*N_DAC_CHIPS-1:0] i_dac_sync_n,
  input wire [N_LEDS-1:0]             i_led
);

  int n_pass = 0;
  int n_fail = 0;
  int led_err = 0;
  int led_moves = 0;

  // adc capture
  logic                   adc_sclk_q = 1'b0;
  logic [N_ADCS-1:0]      adc_sen_q = '1;
  logic [ADC_FRAME_W-1:0] adc_frame = '0;
  int                     adc_bits = 0;
  logic [N_ADCS-1:0]      adc_sen_cap = '1;
  logic                   adc_sen_bad = 1'b0;

  // dac capture, one shift register per bus
  logic [N_DACS-1:0]             dac_sclk_q = '1;
  logic [N_DACS*N_DAC_CHIPS-1:0] sync_q = '1;
  logic [DAC_FRAME_W-1:0]        dac_frame [N_DACS];
  int                            dac_bits [N_DACS];
  logic [N_DACS-1:0]             din_seen = '0;
  logic [N_DACS*N_DAC_CHIPS-1:0] sync_cap = '1;

  // led tracking
  logic [N_LEDS-1:0] led_q = '0;
  logic              dir_up = 1'b1;

  always @(posedge i_lclk) begin
    adc_sclk_q <= i_adc_sclk;
    adc_sen_q  <= i_adc_sen_n;
    // frame starts when an enable first drops
    if (&adc_sen_q && !(&i_adc_sen_n)) begin
      adc_frame   <= '0;
      adc_bits    <= 0;
      adc_sen_cap <= i_adc_sen_n;
      adc_sen_bad <= 1'b0;
    end else if (!adc_sclk_q && i_adc_sclk) begin
      // adc takes data on rising sclk
      adc_frame <= {adc_frame[ADC_FRAME_W-2:0], i_adc_sdata};
      adc_bits  <= adc_bits + 1;
      if (i_adc_sen_n != adc_sen_cap) adc_sen_bad <= 1'b1;
    end
  end

  always @(posedge i_lclk) begin
    dac_sclk_q <= i_dac_sclk;
    sync_q     <= i_dac_sync_n;
    if (&sync_q && !(&i_dac_sync_n)) begin
      for (int b = 0; b < N_DACS; b++) begin
        dac_frame[b] <= '0;
        dac_bits[b]  <= 0;
      end
      din_seen <= '0;
      sync_cap <= i_dac_sync_n;
    end else begin
      for (int b = 0; b < N_DACS; b++) begin
        // dac takes data on falling sclk
        if (dac_sclk_q[b] && !i_dac_sclk[b]) begin
          dac_frame[b] <= {dac_frame[b][DAC_FRAME_W-2:0], i_dac_din[b]};
          dac_bits[b]  <= dac_bits[b] + 1;
        end
      end
      din_seen <= din_seen | i_dac_din;
    end
  end

  // one-hot, adjacent steps, reversal only at the ends
  always @(posedge i_lclk) begin
    led_q <= i_led;
    if (!i_lclk_rst && led_q != '0 && i_led != led_q) begin
      led_moves <= led_moves + 1;
      if (!$onehot(i_led) || (i_led != (led_q << 1) && i_led != (led_q >> 1))) begin
        $display("mismatch at %0t: led moved from %b to %b", $time, led_q, i_led);
        led_err <= led_err + 1;
      end else if ((i_led == (led_q << 1)) != dir_up && !led_q[0] && !led_q[N_LEDS-1]) begin
        $display("mismatch at %0t: led reversed in the middle at %b", $time, led_q);
        led_err <= led_err + 1;
      end
      dir_up <= (i_led == (led_q << 1));
    end
  end

  task automatic record(input string name, input bit ok);
    if (ok) n_pass++;
    else n_fail++;
    $display("test %0d %s %s", n_pass + n_fail, name, ok ? "ok" : "fail");
  endtask

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp, inout bit ok);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    bit ok;
    ok = 1'b1;
    compare(name, got, exp, ok);
    record(name, ok);
  endtask

  task automatic check_adc(input logic [N_ADCS-1:0] sel, input logic [ADC_FRAME_W-1:0] frame);
    bit ok;
    ok = 1'b1;
    compare("adc bit count", adc_bits, ADC_FRAME_W, ok);
    compare("adc frame", 32'(adc_frame), 32'(frame), ok);
    compare("adc enables", 32'(adc_sen_cap), {{(32-N_ADCS){1'b0}}, ~sel}, ok);
    compare("adc enables idle", 32'(i_adc_sen_n), 32'({N_ADCS{1'b1}}), ok);
    if (adc_sen_bad) begin
      $display("adc enables changed in the middle of the frame");
      ok = 1'b0;
    end
    record("adc frame", ok);
  endtask

  task automatic check_dac(input logic [N_DACS-1:0] bus, input logic [DAC_FRAME_W-1:0] frame,
                           input logic [N_DACS*N_DAC_CHIPS-1:0] sync);
    bit ok;
    ok = 1'b1;
    for (int b = 0; b < N_DACS; b++) begin
      if (bus[b]) begin
        compare("dac bit count", dac_bits[b], DAC_FRAME_W, ok);
        compare("dac frame", dac_frame[b], frame, ok);
      end else if (dac_bits[b] != 0 || din_seen[b]) begin
        $display("dac bus %0d toggled while not selected", b);
        ok = 1'b0;
      end
    end
    compare("dac sync", 32'(sync_cap), 32'(sync), ok);
    record("dac frame", ok);
  endtask

  task automatic report_led();
    if (led_moves == 0) $display("leds never moved");
    record("led sweep", led_err == 0 && led_moves > 0);
  endtask

endmodule

`default_nettype wire

//--- testbench/tb_mdom_top.sv
//**********************************************************
// mdom slow-control testbench
// stim-file driven axi4-lite master, adc model, summary
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mdom_top;
  import mdom_pkg::*;

  typedef enum int {OP_WR = 0, OP_RD = 1, OP_ADC = 2, OP_DAC = 3, OP_LED = 4} op_t;

  localparam int LINE_CYCLES = DAC_FRAME_W * 2 * SPI_HALF_PERIOD + 1 + 64;

  logic lclk = 1'b0;
  logic lclk_rst = 1'b1;
  logic awvalid, wvalid, bready, arvalid, rready, adc_sdout;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [AXI_DATA_W-1:0] wdata;
  wire awready, wready, bvalid, arready, rvalid, adc_reset, adc_sclk, adc_sdata;
  wire [1:0] bresp, rresp;
  wire [AXI_DATA_W-1:0] rdata;
  wire [N_ADCS-1:0] adc_sen_n;
  wire [N_DACS-1:0] dac_sclk, dac_din;
  wire [N_DACS*N_DAC_CHIPS-1:0] dac_sync_n;
  wire [N_LEDS-1:0] led;

  // stim lines
  int ops[$];
  logic [31:0] idxs[$], datas[$], exps[$];
  int limit = 0;
  int cyc = 0;

  // adc serial-out model
  logic [ADC_FRAME_W-1:0] model_word = '0;
  logic [ADC_FRAME_W-1:0] model_q = '0;
  logic                   model_sclk_q = 1'b0;

  always #50 lclk = ~lclk;

  mdom_top UUT (
    .i_lclk(lclk), .i_lclk_rst(lclk_rst),
    .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
    .i_wvalid(wvalid), .i_wdata(wdata), .o_wready(wready),
    .o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
    .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
    .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .i_rready(rready),
    .o_adc_reset(adc_reset), .o_adc_sen_n(adc_sen_n), .o_adc_sclk(adc_sclk),
    .o_adc_sdata(adc_sdata), .i_adc_sdout(adc_sdout),
    .o_dac_sclk(dac_sclk), .o_dac_din(dac_din), .o_dac_sync_n(dac_sync_n),
    .o_led(led)
  );

  tb_mdom_checker chk (
    .i_lclk(lclk), .i_lclk_rst(lclk_rst),
    .i_adc_sclk(adc_sclk), .i_adc_sdata(adc_sdata), .i_adc_sen_n(adc_sen_n),
    .i_dac_sclk(dac_sclk), .i_dac_din(dac_din), .i_dac_sync_n(dac_sync_n),
    .i_led(led)
  );

  // word reloads while idle, next bit when sclk falls back to idle
  always @(posedge lclk) begin
    model_sclk_q <= adc_sclk;
    if (&adc_sen_n) begin
      model_q   <= model_word;
      adc_sdout <= model_word[ADC_FRAME_W-1];
    end else if (model_sclk_q && !adc_sclk) begin
      model_q   <= model_q << 1;
      adc_sdout <= model_q[ADC_FRAME_W-2];
    end
  end

  always @(posedge lclk) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // readable field of each plain register, zero where there is no read-back
  function automatic logic [31:0] field_mask(input logic [REG_ADDR_W-1:0] idx);
    case (idx)
      REG_ADC_RESET:    return 32'h1;
      REG_ADC_SPI_SEL:  return 32'h3f;
      REG_ADC_WR_HI:    return 32'hff;
      REG_ADC_WR_LO:    return 32'hffff;
      REG_DAC_SPI_SEL:  return 32'h7;
      REG_DAC_CHIP_SEL: return 32'h7;
      REG_DAC_WR_HI:    return 32'hffff;
      REG_DAC_WR_LO:    return 32'hffff;
      default:          return 32'h0;
    endcase
  endfunction

  task automatic axi_write(input logic [REG_ADDR_W-1:0] idx, input logic [31:0] data);
    int dly;
    @(posedge lclk);
    awvalid <= 1'b1;
    awaddr  <= {idx, 2'b00};
    wvalid  <= 1'b1;
    wdata   <= data;
    do @(posedge lclk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    dly = $urandom_range(3);
    repeat (dly) @(posedge lclk);
    bready <= 1'b1;
    do @(posedge lclk); while (!bvalid);
    bready <= 1'b0;
    chk.check_value("write response", {30'd0, bresp}, 32'd0);
  endtask

  task automatic axi_read(input logic [REG_ADDR_W-1:0] idx, output logic [31:0] data,
                          output logic [1:0] resp);
    int dly;
    @(posedge lclk);
    arvalid <= 1'b1;
    araddr  <= {idx, 2'b00};
    do @(posedge lclk); while (!arready);
    arvalid <= 1'b0;
    dly = $urandom_range(3);
    repeat (dly) @(posedge lclk);
    rready <= 1'b1;
    do @(posedge lclk); while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  // poll a task register until the engine has acked
  task automatic wait_task_done(input logic [REG_ADDR_W-1:0] idx);
    logic [31:0] rd;
    logic [1:0]  resp;
    do axi_read(idx, rd, resp); while (rd[0]);
  endtask

  task automatic load_stim();
    int fd;
    int n;
    string line;
    int op;
    logic [31:0] a, d, e;
    fd = $fopen("testbench/mdom_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h", op, a, d, e);
      if (n == 4) begin
        ops.push_back(op);
        idxs.push_back(a);
        datas.push_back(d);
        exps.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    logic [31:0] rd;
    logic [1:0]  resp;
    void'($urandom(53562));
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    adc_sdout = 1'b0;
    load_stim();
    limit = (ops.size() + 1) * LINE_CYCLES;
    if (ops.size() == 0) $display("no stimulus lines were read");
    repeat (5) @(posedge lclk);
    lclk_rst <= 1'b0;
    for (int i = 0; i < ops.size(); i++) begin
      case (op_t'(ops[i]))
        OP_WR: begin
          axi_write(idxs[i][REG_ADDR_W-1:0], datas[i]);
          if (idxs[i][REG_ADDR_W-1:0] == REG_ADC_RESET) begin
            chk.check_value("adc reset pin", {31'd0, adc_reset}, {31'd0, datas[i][0]});
          end
          // plain registers read back the written field
          if (field_mask(idxs[i][REG_ADDR_W-1:0]) != 32'h0) begin
            axi_read(idxs[i][REG_ADDR_W-1:0], rd, resp);
            chk.check_value("read back", rd,
                            datas[i] & field_mask(idxs[i][REG_ADDR_W-1:0]));
          end
        end
        OP_RD: begin
          axi_read(idxs[i][REG_ADDR_W-1:0], rd, resp);
          chk.check_value("read data", rd, exps[i]);
          chk.check_value("read response", {30'd0, resp}, 32'd0);
        end
        OP_ADC: begin
          model_word <= exps[i][ADC_FRAME_W-1:0];
          axi_write(REG_ADC_SPI_TASK, 32'd1);
          wait_task_done(REG_ADC_SPI_TASK);
          chk.check_adc(idxs[i][N_ADCS-1:0], datas[i][ADC_FRAME_W-1:0]);
        end
        OP_DAC: begin
          axi_write(REG_DAC_SPI_TASK, 32'd1);
          wait_task_done(REG_DAC_SPI_TASK);
          chk.check_dac(idxs[i][N_DACS-1:0], datas[i], exps[i][N_DACS*N_DAC_CHIPS-1:0]);
        end
        OP_LED: begin
          repeat (datas[i]) @(posedge lclk);
          chk.report_led();
        end
        default: chk.record("unknown stimulus opcode", 1'b0);
      endcase
    end
    $display("summary: %0d passed, %0d failed, %0d led errors",
             chk.n_pass, chk.n_fail, chk.led_err);
    if (chk.n_fail == 0 && chk.led_err == 0 && ops.size() > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/mdom_stim.txt
# op index data expect, all hex; op 0 write, 1 read-compare, 2 adc frame, 3 dac frame, 4 led watch
# adc: index = enable select, data = mosi frame, expect = sdout word; dac: index = bus, expect = sync_n
1 fff 0 2
1 123 0 0
0 ee5 1 0
1 ee5 0 1
0 ee4 4 0
1 ee4 0 4
0 ee2 a5 0
0 ee1 3c96 0
2 4 a53c96 5a5a81
1 ee0 0 81
1 ee3 0 0
0 edf 2 0
0 ede 4 0
0 edc 1234 0
0 edb abcd 0
3 2 1234abcd 1df
4 0 40 0

//--- flist.f
verilog/mdom_pkg.sv
verilog/mdom_axil_regs.sv
verilog/mdom_spi_master.sv
verilog/mdom_serial_ctrl.sv
verilog/mdom_led_sweep.sv
verilog/mdom_top.sv
testbench/tb_mdom_checker.sv
testbench/tb_mdom_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mdom slow-control testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_mdom_top -o sim_mdom
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_mdom)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1
